// ==== htu_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module htu_arbiter #(
  parameter int  NUM_SETS = 4,
  localparam int SET_W    = $clog2(NUM_SETS)
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 lkp_valid_i,
  input  logic [SET_W-1:0]     lkp_set_i,
  input  htu_cfg_pkg::tag_t    lkp_tag_i,
  input  logic                 lkp_offset_i,
  input  logic                 trn_valid_i,
  input  logic [SET_W-1:0]     trn_set_i,
  input  htu_cfg_pkg::tag_t    trn_tag_i,
  input  logic                 trn_offset_i,
  input  htu_cfg_pkg::status_t trn_status_i,
  output logic                 trn_pend_o,
  htu_bus_if.arb               bus
);

  import htu_op_pkg::*;

  htu_req_t         lkp_req;
  htu_req_t         trn_req;
  htu_req_t         hold_req_q;
  logic [SET_W-1:0] hold_set_q;
  logic             pend_q;
  logic             hold_load;

  assign lkp_req   = '{op: OP_LOOKUP, tag: lkp_tag_i, offset: lkp_offset_i, status: '0};
  assign trn_req   = '{op: OP_TRAIN, tag: trn_tag_i, offset: trn_offset_i, status: trn_status_i};
  assign hold_load = trn_valid_i && (lkp_valid_i || pend_q); // Train loses this cycle

  // Lookup first, then the held train, then a new one
  always_comb begin
    bus.valid   = lkp_valid_i || pend_q || trn_valid_i;
    bus.set_idx = trn_set_i;
    bus.req     = trn_req;
    if (lkp_valid_i) begin
      bus.set_idx = lkp_set_i;
      bus.req     = lkp_req;
    end else if (pend_q) begin
      bus.set_idx = hold_set_q;
      bus.req     = hold_req_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
    end else if (hold_load) begin
      pend_q <= 1'b1;
    end else if (!lkp_valid_i) begin
      pend_q <= 1'b0; // Held train drains
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      hold_req_q <= trn_req;
      hold_set_q <= trn_set_i;
    end
  end

  assign trn_pend_o = pend_q;

endmodule

`default_nettype wire

// ==== htu_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module htu_bank #(
  parameter int  NUM_SETS = 4,
  localparam int SET_W    = $clog2(NUM_SETS)
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 lkp_valid_i,
  input  logic [SET_W-1:0]     lkp_set_i,
  input  htu_cfg_pkg::tag_t    lkp_tag_i,
  input  logic                 lkp_offset_i,
  input  logic                 trn_valid_i,
  input  logic [SET_W-1:0]     trn_set_i,
  input  htu_cfg_pkg::tag_t    trn_tag_i,
  input  logic                 trn_offset_i,
  input  htu_cfg_pkg::status_t trn_status_i,
  output logic                 lkp_resp_valid_o,
  output logic                 lkp_hit_o,
  output htu_cfg_pkg::way_t    lkp_way_o,
  output htu_cfg_pkg::status_t lkp_status_o,
  output htu_cfg_pkg::cnt_t    lkp_cnt_o,
  output logic                 trn_pend_o
);

  htu_bus_if #(.NUM_SETS(NUM_SETS)) bus_inst (.clk_i(clk_i));

  htu_arbiter #(.NUM_SETS(NUM_SETS)) htu_arbiter_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lkp_valid_i  (lkp_valid_i),
    .lkp_set_i    (lkp_set_i),
    .lkp_tag_i    (lkp_tag_i),
    .lkp_offset_i (lkp_offset_i),
    .trn_valid_i  (trn_valid_i),
    .trn_set_i    (trn_set_i),
    .trn_tag_i    (trn_tag_i),
    .trn_offset_i (trn_offset_i),
    .trn_status_i (trn_status_i),
    .trn_pend_o   (trn_pend_o),
    .bus          (bus_inst.arb)
  );

  htu_set_array #(.NUM_SETS(NUM_SETS)) htu_set_array_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus      (bus_inst.arr)
  );

  assign lkp_resp_valid_o = bus_inst.resp_valid;
  assign lkp_hit_o        = bus_inst.resp.hit;
  assign lkp_way_o        = bus_inst.resp.way;
  assign lkp_status_o     = bus_inst.resp.status;
  assign lkp_cnt_o        = bus_inst.resp.cnt;

endmodule

`default_nettype wire

// ==== htu_bank_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module htu_bank_assert (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 lkp_valid_i,
  input logic                 trn_valid_i,
  input logic                 trn_pend_i,
  input logic                 lkp_resp_valid_i,
  input logic                 lkp_hit_i,
  input htu_cfg_pkg::way_t    lkp_way_i,
  input htu_cfg_pkg::status_t lkp_status_i,
  input htu_cfg_pkg::cnt_t    lkp_cnt_i
);

  // Only back-pressure on the train channel
  assert property (@(posedge clk_i) disable iff (!arst_n_i) trn_pend_i |-> !trn_valid_i)
    else $error("train strobe while a held train is pending");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) lkp_valid_i |=> lkp_resp_valid_i)
    else $error("lookup response missing one cycle after the strobe");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   !lkp_valid_i |=> !lkp_resp_valid_i)
    else $error("lookup response without a strobe one cycle before");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   !lkp_hit_i |-> ((lkp_way_i == '0) && (lkp_status_i == '0) &&
                                   (lkp_cnt_i == '0)))
    else $error("lookup miss with nonzero response fields");

endmodule

bind htu_bank htu_bank_assert htu_bank_assert_inst (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .lkp_valid_i      (lkp_valid_i),
  .trn_valid_i      (trn_valid_i),
  .trn_pend_i       (trn_pend_o),
  .lkp_resp_valid_i (lkp_resp_valid_o),
  .lkp_hit_i        (lkp_hit_o),
  .lkp_way_i        (lkp_way_o),
  .lkp_status_i     (lkp_status_o),
  .lkp_cnt_i        (lkp_cnt_o)
);

`default_nettype wire

// ==== htu_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface htu_bus_if #(
  parameter int NUM_SETS = 4
) (
  input logic clk_i
);

  import htu_op_pkg::*;

  logic                        valid; // One-cycle grant strobe
  logic [$clog2(NUM_SETS)-1:0] set_idx;
  htu_req_t                    req;
  htu_resp_t                   resp;
  logic                        resp_valid;

  modport arb (
    input  clk_i,
    output valid,
    output set_idx,
    output req,
    input  resp,
    input  resp_valid
  );

  modport arr (
    input  clk_i,
    input  valid,
    input  set_idx,
    input  req,
    output resp,
    output resp_valid
  );

endinterface

`default_nettype wire

// ==== htu_cfg_pkg.sv ====
`default_nettype none

package htu_cfg_pkg;

  localparam int NUM_WAYS = 8;
  localparam int TAG_W    = 22; // Address bits 31 to 10
  localparam int STATUS_W = 2;
  localparam int CNT_W    = 3;
  localparam int PLRU_W   = NUM_WAYS - 1; // Binary tree over the ways
  localparam int WAY_W    = $clog2(NUM_WAYS);

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [STATUS_W-1:0] status_t;
  typedef logic [CNT_W-1:0]    cnt_t; // Saturates at all ones

endpackage

`default_nettype wire

// ==== htu_input.txt ====
# kind set tag offset status exp_hit exp_way exp_status exp_cnt gap
# gap 0 keeps a row right after the one before it, no random idle cycles
# Reset, every set misses
L  0 000000 0 0  0 0 0 0  1
L  3 3fffff 1 0  0 0 0 0  1
# Allocation in set 1 fills ways 0 1 2, status per offset
T  1 0a0001 0 2  0 0 0 0  1
T  1 0a0002 1 3  0 0 0 0  1
T  1 0a0003 0 1  0 0 0 0  1
L  1 0a0001 0 0  1 0 2 0  1
L  1 0a0001 1 0  1 0 0 1  1
L  1 0a0002 1 0  1 1 3 0  1
L  1 0a0003 0 0  1 2 1 0  1
L  2 0a0001 0 0  0 0 0 0  1
# Reference counter saturates at 7, a train hit keeps it
L  1 0a0001 0 0  1 0 2 2  1
L  1 0a0001 0 0  1 0 2 3  1
L  1 0a0001 0 0  1 0 2 4  1
L  1 0a0001 0 0  1 0 2 5  1
L  1 0a0001 0 0  1 0 2 6  1
L  1 0a0001 0 0  1 0 2 7  1
L  1 0a0001 0 0  1 0 2 7  1
T  1 0a0003 1 3  0 0 0 0  1
L  1 0a0003 1 0  1 2 3 1  1
# Set 2 full, touches of ways 0 5 2 leave the tree pointing at way 6
T  2 0b0000 0 1  0 0 0 0  1
T  2 0b0001 0 2  0 0 0 0  1
T  2 0b0002 0 3  0 0 0 0  1
T  2 0b0003 0 1  0 0 0 0  1
T  2 0b0004 0 2  0 0 0 0  1
T  2 0b0005 0 3  0 0 0 0  1
T  2 0b0006 0 1  0 0 0 0  1
T  2 0b0007 0 2  0 0 0 0  1
L  2 0b0000 0 0  1 0 1 0  1
L  2 0b0005 0 0  1 5 3 0  1
L  2 0b0002 0 0  1 2 3 0  1
T  2 0b00aa 1 2  0 0 0 0  1
L  2 0b00aa 1 0  1 6 2 0  1
L  2 0b0006 0 0  0 0 0 0  1
# Lookup and train together, the lookup sees the old state
T  3 0c0001 0 1  0 0 0 0  1
LT 3 0c0001 0 2  1 0 1 0  1
L  3 0c0001 0 0  1 0 2 1  0
LT 3 0c0002 1 3  0 0 0 0  1
L  3 0c0002 1 0  1 1 3 0  0

// ==== htu_op_pkg.sv ====
`default_nettype none

package htu_op_pkg;

  typedef enum logic {
    OP_LOOKUP = 1'b0,
    OP_TRAIN  = 1'b1
  } htu_op_e;

  // Set index travels beside the request
  typedef struct packed {
    htu_op_e               op;
    htu_cfg_pkg::tag_t     tag;
    logic                  offset; // Half of the region
    htu_cfg_pkg::status_t  status; // Train only
  } htu_req_t;

  typedef struct packed {
    logic                  hit;
    htu_cfg_pkg::way_t     way;
    htu_cfg_pkg::status_t  status;
    htu_cfg_pkg::cnt_t     cnt; // Value before the increment
  } htu_resp_t;

endpackage

`default_nettype wire

// ==== htu_set_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module htu_set_array #(
  parameter int NUM_SETS = 4
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  htu_bus_if.arr bus
);

  import htu_op_pkg::*;

  logic [NUM_SETS-1:0] sel;
  htu_resp_t           set_resp [NUM_SETS];
  htu_resp_t           resp_q;
  logic                resp_valid_q;
  logic                lkp_grant;

  // One-hot select qualified by the strobe
  always_comb begin
    sel = '0;
    if (bus.valid) begin
      sel[bus.set_idx] = 1'b1;
    end
  end

  for (genvar g = 0; g < NUM_SETS; g++) begin : g_set
    htu_set_status htu_set_status_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .sel_i    (sel[g]),
      .req_i    (bus.req),
      .resp_o   (set_resp[g])
    );
  end

  assign lkp_grant = bus.valid && (bus.req.op == OP_LOOKUP);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
      resp_q       <= '0;
    end else begin
      resp_valid_q <= lkp_grant;
      if (lkp_grant) begin
        resp_q <= set_resp[bus.set_idx]; // State before this edge
      end
    end
  end

  assign bus.resp       = resp_q;
  assign bus.resp_valid = resp_valid_q;

endmodule

`default_nettype wire

// ==== htu_set_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module htu_set_status (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  sel_i,
  input  htu_op_pkg::htu_req_t  req_i,
  output htu_op_pkg::htu_resp_t resp_o
);

  import htu_cfg_pkg::*;
  import htu_op_pkg::*;

  logic [NUM_WAYS-1:0] valid_q;
  tag_t                tag_q [NUM_WAYS];
  cnt_t                cnt_q [NUM_WAYS];
  status_t [1:0]       status_q [NUM_WAYS]; // Indexed by offset
  logic [PLRU_W-1:0]   plru_q;

  logic                hit;
  way_t                hit_way;
  logic                inv_found;
  way_t                inv_way;
  logic                vict_hi;
  logic                vict_mid;
  logic                vict_lo;
  way_t                acc_way;
  logic [PLRU_W-1:0]   plru_touched;
  logic                is_train;

  // Point every node on the path of w away from it
  function automatic logic [PLRU_W-1:0] plru_touch(logic [PLRU_W-1:0] tree, way_t w);
    logic [PLRU_W-1:0] t;
    t                 = tree;
    t[0]              = ~w[2];
    t[1 + int'(w[2])] = ~w[1];
    t[3 + int'(w[2:1])] = ~w[0];
    return t;
  endfunction

  // Descending loops so the lowest way wins
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (valid_q[w] && (tag_q[w] == req_i.tag)) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w]) begin
        inv_found = 1'b1;
        inv_way   = way_t'(w);
      end
    end
  end

  // Tree walk toward the victim
  assign vict_hi  = plru_q[0];
  assign vict_mid = plru_q[1 + int'(vict_hi)];
  assign vict_lo  = plru_q[3 + int'({vict_hi, vict_mid})];

  assign acc_way      = hit ? hit_way : (inv_found ? inv_way : {vict_hi, vict_mid, vict_lo});
  assign plru_touched = plru_touch(plru_q, acc_way);
  assign is_train     = (req_i.op == OP_TRAIN);

  always_comb begin
    resp_o = '0; // Miss reports all zeros
    if (hit) begin
      resp_o.hit    = 1'b1;
      resp_o.way    = hit_way;
      resp_o.status = status_q[hit_way][req_i.offset];
      resp_o.cnt    = cnt_q[hit_way];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      plru_q  <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_q[w]    <= '0;
        cnt_q[w]    <= '0;
        status_q[w] <= '0;
      end
    end else if (sel_i) begin
      if (hit || is_train) begin
        plru_q <= plru_touched;
      end
      if (!is_train) begin
        if (hit && (cnt_q[hit_way] != '1)) begin
          cnt_q[hit_way] <= cnt_q[hit_way] + 1'b1; // Saturating
        end
      end else if (hit) begin
        status_q[hit_way][req_i.offset] <= req_i.status;
      end else begin
        valid_q[acc_way]                 <= 1'b1; // Allocate victim
        tag_q[acc_way]                   <= req_i.tag;
        status_q[acc_way][!req_i.offset] <= '0;
        status_q[acc_way][req_i.offset]  <= req_i.status;
        cnt_q[acc_way]                   <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the HTU bank testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_htu_bank
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_htu_bank > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
else
  exit 1
fi

// ==== sim.f ====
htu_cfg_pkg.sv
htu_op_pkg.sv
htu_bus_if.sv
htu_arbiter.sv
htu_set_status.sv
htu_set_array.sv
htu_bank.sv
htu_bank_assert.sv
tb_htu_bank.sv

// ==== tb_htu_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_htu_bank;

  import htu_cfg_pkg::*;
  import htu_op_pkg::*;

  localparam int NUM_SETS  = 4;
  localparam int SET_W     = $clog2(NUM_SETS);
  localparam int DRAIN_MAX = 8;
  localparam int RAND_SEED = 32'h4c69_12c1;

  // ASCII row kinds as $fscanf packs them
  localparam logic [15:0] KIND_L   = 16'h004c;
  localparam logic [15:0] KIND_T   = 16'h0054;
  localparam logic [15:0] KIND_LT  = 16'h4c54;
  localparam logic [15:0] KIND_REM = 16'h0023;

  logic             clk_i;
  logic             arst_n_i;
  logic             lkp_valid_i;
  logic [SET_W-1:0] lkp_set_i;
  tag_t             lkp_tag_i;
  logic             lkp_offset_i;
  logic             trn_valid_i;
  logic [SET_W-1:0] trn_set_i;
  tag_t             trn_tag_i;
  logic             trn_offset_i;
  status_t          trn_status_i;
  logic             lkp_resp_valid_o;
  logic             lkp_hit_o;
  way_t             lkp_way_o;
  status_t          lkp_status_o;
  cnt_t             lkp_cnt_o;
  logic             trn_pend_o;

  htu_bank #(.NUM_SETS(NUM_SETS)) htu_bank_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .lkp_valid_i      (lkp_valid_i),
    .lkp_set_i        (lkp_set_i),
    .lkp_tag_i        (lkp_tag_i),
    .lkp_offset_i     (lkp_offset_i),
    .trn_valid_i      (trn_valid_i),
    .trn_set_i        (trn_set_i),
    .trn_tag_i        (trn_tag_i),
    .trn_offset_i     (trn_offset_i),
    .trn_status_i     (trn_status_i),
    .lkp_resp_valid_o (lkp_resp_valid_o),
    .lkp_hit_o        (lkp_hit_o),
    .lkp_way_o        (lkp_way_o),
    .lkp_status_o     (lkp_status_o),
    .lkp_cnt_o        (lkp_cnt_o),
    .trn_pend_o       (trn_pend_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  function automatic string resp_text(input htu_resp_t r);
    return $sformatf("hit %0b way %0d status %0d cnt %0d",
                     r.hit, r.way, r.status, r.cnt);
  endfunction

  task automatic check_resp(input htu_resp_t exp);
    htu_resp_t act;
    act = '{hit: lkp_hit_o, way: lkp_way_o, status: lkp_status_o, cnt: lkp_cnt_o};
    if (act !== exp) begin
      $display("error at time %0t: lkp_resp expected %s actual %s", $time, resp_text(exp),
               resp_text(act));
      abort_run();
    end
  endtask

  task automatic check_resp_valid(input logic exp);
    if (lkp_resp_valid_o !== exp) begin
      $display("error at time %0t: lkp_resp_valid_o expected %0b actual %0b",
               $time, exp, lkp_resp_valid_o);
      abort_run();
    end
  endtask

  task automatic check_pend(input logic exp);
    if (trn_pend_o !== exp) begin
      $display("error at time %0t: trn_pend_o expected %0b actual %0b",
               $time, exp, trn_pend_o);
      abort_run();
    end
  endtask

  // Each row strobes for one cycle and expects the response one edge later
  task automatic run_row(input logic do_lkp, input logic do_trn, input int set_v,
                         input int tag_v, input int off_v, input int st_v,
                         input htu_resp_t exp);
    int wait_cnt;
    @(posedge clk_i);
    lkp_valid_i  <= do_lkp;
    lkp_set_i    <= SET_W'(set_v);
    lkp_tag_i    <= tag_t'(tag_v);
    lkp_offset_i <= off_v[0];
    trn_valid_i  <= do_trn;
    trn_set_i    <= SET_W'(set_v);
    trn_tag_i    <= tag_t'(tag_v);
    trn_offset_i <= off_v[0];
    trn_status_i <= status_t'(st_v);
    @(negedge clk_i);
    check_resp_valid(1'b0);
    check_pend(1'b0);
    @(posedge clk_i);
    lkp_valid_i <= 1'b0;
    trn_valid_i <= 1'b0;
    @(negedge clk_i);
    check_resp_valid(do_lkp);
    if (do_lkp) begin
      check_resp(exp);
    end
    check_pend(do_lkp && do_trn); // Train held behind the lookup
    if (do_lkp && do_trn) begin
      wait_cnt = 0;
      while (trn_pend_o && (wait_cnt < DRAIN_MAX)) begin
        @(negedge clk_i);
        wait_cnt++;
      end
      if (trn_pend_o) begin
        $display("The held train never drained within %0d cycles", DRAIN_MAX);
        abort_run();
      end
      if (wait_cnt != 1) begin
        $display("error at time %0t: trn_pend_o fall expected after 1 idle cycle, actual %0d",
                 $time, wait_cnt);
        abort_run();
      end
    end
  endtask

  initial begin
    logic [15:0]      kind;
    logic [8*128-1:0] line;
    htu_resp_t        exp;
    int               fd;
    int               code;
    int               idle;
    int               rows_done;
    int               row_set;
    int               row_tag;
    int               row_off;
    int               row_st;
    int               row_hit;
    int               row_way;
    int               row_rst;
    int               row_cnt;
    int               row_gap;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    lkp_valid_i  = 1'b0;
    lkp_set_i    = '0;
    lkp_tag_i    = '0;
    lkp_offset_i = 1'b0;
    trn_valid_i  = 1'b0;
    trn_set_i    = '0;
    trn_tag_i    = '0;
    trn_offset_i = 1'b0;
    trn_status_i = '0;
    rows_done    = 0;
    void'($urandom(RAND_SEED));
    fd = $fopen("htu_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file htu_input.txt");
      abort_run();
    end
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_resp_valid(1'b0);
    check_pend(1'b0);
    check_resp('0);
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        break;
      end
      if (kind == KIND_REM) begin
        void'($fgets(line, fd)); // Rest of a comment line
        continue;
      end
      code = $fscanf(fd, "%d %h %d %d %d %d %d %d %d", row_set, row_tag, row_off, row_st,
                     row_hit, row_way, row_rst, row_cnt, row_gap);
      if ((code != 9) || !(kind inside {KIND_L, KIND_T, KIND_LT})) begin
        $display("Stimulus row %0d in htu_input.txt is malformed", rows_done + 1);
        abort_run();
      end
      exp = '{hit: (row_hit != 0), way: way_t'(row_way), status: status_t'(row_rst),
              cnt: cnt_t'(row_cnt)};
      if (row_gap != 0) begin
        idle = $urandom % 3;
        repeat (idle) @(posedge clk_i);
      end
      run_row((kind != KIND_T), (kind != KIND_L), row_set, row_tag, row_off, row_st, exp);
      rows_done++;
    end
    $fclose(fd);
    if (rows_done == 0) begin
      $display("No stimulus rows were read from htu_input.txt");
      abort_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
